/* bench/flash_emu_tb.sv */
// testbench for flash_emu_top; spi reads are only checked after the host has filled the whole image
`timescale 1ns/1ps
`default_nettype none

module flash_emu_tb import flash_emu_pkg::*; ();

	// spi half period in clk cycles, one byte is 16 of them
	localparam int HALF = 20;
	localparam int BYTE_CYCLES = 16 * HALF;
	// opcode, address, dummy and up to 40 data bytes
	localparam int MAX_FRAME_BYTES = 45;
	localparam int N_READS = 6;
	localparam int N_FAST = 4;
	localparam int N_BAD = 3;
	localparam int N_HOST_READS = 200;
	localparam int N_BUSY_WRITES = 40;
	localparam int HOST_WAIT = 200;
	// plus wrap read, wrap fast read, busy read, cut burst and the read after it
	localparam int N_FRAMES = N_READS + N_FAST + N_BAD + 5;
	localparam int SPI_CYCLES = N_FRAMES * (MAX_FRAME_BYTES * BYTE_CYCLES + 3 * HALF);
	localparam int HOST_CYCLES = (4096 + N_HOST_READS + 20 + 2 * N_BUSY_WRITES) * 8
		+ N_BUSY_WRITES * 200;
	localparam int LIMIT_CYCLES = (SPI_CYCLES + HOST_CYCLES) * 3 / 2 + 1000;

	logic       clk;
	logic       arst_n;
	logic       sck;
	logic       cs_n;
	logic       mosi;
	logic       miso;
	logic       host_valid;
	logic       host_ready;
	host_req_t  host_req;
	logic [7:0] host_rdata;
	logic       host_rvalid;
	integer     seed;
	// reference copy of the flash image
	logic [7:0] model [4096];

	flash_emu_top u_flash_emu_top (
		.clk         (clk),
		.arst_n      (arst_n),
		.sck         (sck),
		.cs_n        (cs_n),
		.mosi        (mosi),
		.miso        (miso),
		.host_valid  (host_valid),
		.host_ready  (host_ready),
		.host_req    (host_req),
		.host_rdata  (host_rdata),
		.host_rvalid (host_rvalid)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stop_run();
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic check(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (act !== exp) begin
			$display("error %s expected %02h actual %02h", name, exp, act);
			stop_run();
		end
	endtask

	// every wait ends 1 ns after a rising edge, where inputs are driven
	task automatic wait_clks(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r % 32'(n));
	endfunction

	function automatic logic [7:0] rand_byte();
		return 8'($random(seed));
	endfunction

	// random spi address that starts near the image end, so a long burst wraps
	function automatic logic [23:0] wrap_addr();
		logic [23:0] a;
		a = 24'($random(seed));
		a[11:0] = 12'hFF0 - 12'(rand_below(16));
		return a;
	endfunction

	// mode 0 master, msb first; a short nbits leaves the byte unfinished
	task automatic spi_byte(input logic [7:0] tx, input int nbits, output logic [7:0] rx);
		logic [7:0] sh;
		sh = tx;
		rx = 8'h00;
		for (int i = 0; i < nbits; i++) begin
			mosi = sh[7];
			sh = {sh[6:0], 1'b0};
			wait_clks(HALF);
			sck = 1'b1;
			// miso sampled on the rising edge
			rx = {rx[6:0], miso};
			wait_clks(HALF);
			sck = 1'b0;
		end
	endtask

	task automatic frame_begin();
		cs_n = 1'b0;
		wait_clks(HALF);
	endtask

	task automatic frame_end();
		wait_clks(HALF);
		cs_n = 1'b1;
		mosi = 1'b0;
		wait_clks(2 * HALF);
	endtask

	// opcode and three address bytes, msb first
	task automatic send_cmd(input logic [7:0] op, input logic [23:0] addr);
		logic [7:0] rx;
		spi_byte(op, 8, rx);
		spi_byte(addr[23:16], 8, rx);
		spi_byte(addr[15:8], 8, rx);
		spi_byte(addr[7:0], 8, rx);
	endtask

	task automatic read_burst(input string name, input logic fast, input logic [23:0] addr,
		input int len);
		logic [7:0]  rx;
		logic [11:0] a;
		frame_begin();
		send_cmd(fast ? 8'h0B : 8'h03, addr);
		// fast read has one dummy byte before data
		if (fast) begin
			spi_byte(rand_byte(), 8, rx);
		end
		// upper address bits are dropped, the image wraps at 4 KiB
		a = addr[11:0];
		for (int i = 0; i < len; i++) begin
			spi_byte(rand_byte(), 8, rx);
			check(name, model[a], rx);
			a = a + 12'd1;
		end
		frame_end();
	endtask

	// unknown opcode, every miso byte of the frame must be 0xff
	task automatic bad_frame(input logic [7:0] op);
		logic [7:0] rx;
		frame_begin();
		spi_byte(op, 8, rx);
		check("bad_opcode", 8'hFF, rx);
		for (int i = 0; i < 6; i++) begin
			spi_byte(rand_byte(), 8, rx);
			check("bad_opcode", 8'hFF, rx);
		end
		frame_end();
	endtask

	// two good bytes, then cs_n rises part way into the third
	task automatic cut_burst(input logic [23:0] addr);
		logic [7:0]  rx;
		logic [11:0] a;
		frame_begin();
		send_cmd(8'h03, addr);
		a = addr[11:0];
		for (int i = 0; i < 2; i++) begin
			spi_byte(rand_byte(), 8, rx);
			check("cut_burst", model[a], rx);
			a = a + 12'd1;
		end
		spi_byte(rand_byte(), 2 + rand_below(5), rx);
		frame_end();
	endtask

	task automatic host_send(input logic we, input logic [11:0] addr, input logic [7:0] data);
		int n;
		host_req.we   = we;
		host_req.addr = addr;
		host_req.data = data;
		host_valid    = 1'b1;
		n = 0;
		while (!host_ready && n < HOST_WAIT) begin
			wait_clks(1);
			n++;
		end
		if (!host_ready) begin
			$display("host_ready stayed low, the host request was never accepted");
			stop_run();
		end
		// transfer happens on this edge
		wait_clks(1);
		host_valid = 1'b0;
	endtask

	task automatic host_write(input logic [11:0] addr, input logic [7:0] data);
		host_send(1'b1, addr, data);
		model[addr] = data;
	endtask

	task automatic host_read(input string name, input logic [11:0] addr);
		int n;
		host_send(1'b0, addr, 8'h00);
		n = 0;
		while (!host_rvalid && n < HOST_WAIT) begin
			wait_clks(1);
			n++;
		end
		if (!host_rvalid) begin
			$display("host_rvalid never came back for a host read");
			stop_run();
		end
		check(name, model[addr], host_rdata);
	endtask

	// host writes away from the spi window [base, base+len), then reads them back
	task automatic host_traffic(input logic [11:0] base, input int len);
		logic [11:0] addrs [N_BUSY_WRITES];
		for (int i = 0; i < N_BUSY_WRITES; i++) begin
			wait_clks(rand_below(200));
			addrs[i] = base + 12'(len) + 12'(rand_below(4096 - len));
			host_write(addrs[i], rand_byte());
		end
		for (int i = 0; i < N_BUSY_WRITES; i++) begin
			host_read("busy_host", addrs[i]);
		end
	endtask

	// watchdog
	initial begin
		repeat (LIMIT_CYCLES) @(posedge clk);
		$display("watchdog expired, the tests did not finish in time");
		stop_run();
	end

	initial begin
		logic [7:0]  op;
		logic [23:0] addr;
		seed       = 34;
		arst_n     = 1'b0;
		sck        = 1'b0;
		cs_n       = 1'b1;
		mosi       = 1'b0;
		host_valid = 1'b0;
		host_req   = '0;
		repeat (8) @(posedge clk);
		#1;
		arst_n = 1'b1;
		wait_clks(2);
		check("reset_host_ready", 8'h01, {7'd0, host_ready});
		check("reset_host_rvalid", 8'h00, {7'd0, host_rvalid});
		check("reset_miso", 8'h01, {7'd0, miso});

		// fill the whole image, then spot check
		for (int i = 0; i < 4096; i++) begin
			host_write(12'(i), rand_byte());
		end
		for (int i = 0; i < N_HOST_READS; i++) begin
			host_read("host_fill", 12'(rand_below(4096)));
		end

		for (int i = 0; i < N_READS; i++) begin
			read_burst("read", 1'b0, 24'($random(seed)), 1 + rand_below(40));
		end
		read_burst("read_wrap", 1'b0, wrap_addr(), 40);

		for (int i = 0; i < N_FAST; i++) begin
			read_burst("fast_read", 1'b1, 24'($random(seed)), 1 + rand_below(40));
		end
		read_burst("fast_read_wrap", 1'b1, wrap_addr(), 40);

		for (int i = 0; i < N_BAD; i++) begin
			op = rand_byte();
			while (op == 8'h03 || op == 8'h0B) begin
				op = rand_byte();
			end
			bad_frame(op);
		end
		// image must be untouched by the ignored frames
		for (int i = 0; i < 20; i++) begin
			host_read("after_bad_opcode", 12'(rand_below(4096)));
		end

		// spi burst and host traffic at the same time
		addr = 24'($random(seed));
		fork
			read_burst("busy_read", 1'b0, addr, 40);
			host_traffic(addr[11:0], 40);
		join
		wait_clks(1);
		check("busy_host_ready", 8'h01, {7'd0, host_ready});

		cut_burst(24'($random(seed)));
		read_burst("after_cut", 1'b0, 24'($random(seed)), 1 + rand_below(40));

		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

/* flash_emu_top.f */
source/flash_emu_pkg.sv
source/spi_pin_sampler.sv
source/flash_read_engine.sv
source/host_port.sv
source/mem_arbiter.sv
source/image_ram.sv
source/flash_emu_top.sv
bench/flash_emu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the flash emulator testbench with verilator and run it
# exit status is nonzero when the build or the simulation fails
cd "$(dirname "$0")" \
	&& verilator --binary --timing --top-module flash_emu_tb -f flash_emu_top.f \
	&& ./obj_dir/Vflash_emu_tb \
	|| exit 1

/* source/flash_emu_pkg.sv */
// shared types for the flash emulator; image is 4 KiB, upper spi address bits are ignored
`default_nettype none

package flash_emu_pkg;

	// image address width, 2**12 bytes of flash image
	localparam int MEM_ADDR_BITS = 12;

	// address bytes that follow a read opcode
	localparam int SPI_ADDR_BYTES = 3;

	// supported flash opcodes
	// anything else is answered with 0xff
	typedef enum logic [7:0] {
		OP_READ      = 8'h03,
		OP_FAST_READ = 8'h0B
	} spi_op_t;

	// wishbone classic, master to slave
	typedef struct packed {
		logic                     cyc;
		logic                     stb;
		logic                     we;
		logic [MEM_ADDR_BITS-1:0] adr;
		logic [7:0]               dat;
	} wb_req_t;

	// wishbone classic, slave to master
	typedef struct packed {
		logic       ack;
		logic [7:0] dat;
	} wb_rsp_t;

	// one byte request from the host side
	typedef struct packed {
		logic                     we;
		logic [MEM_ADDR_BITS-1:0] addr;
		logic [7:0]               data;
	} host_req_t;

endpackage

`default_nettype wire

/* source/flash_emu_top.sv */
// spi flash emulator top; single clock, spi pins are asynchronous and oversampled
`timescale 1ns/1ps
`default_nettype none

module flash_emu_top import flash_emu_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       sck,
	input  logic       cs_n,
	input  logic       mosi,
	output logic       miso,
	input  logic       host_valid,
	output logic       host_ready,
	input  host_req_t  host_req,
	output logic [7:0] host_rdata,
	output logic       host_rvalid
);

	logic [7:0] rx_data;
	logic       rx_valid;
	logic       frame_start;
	logic [7:0] tx_data;
	// engine and host port buses to the arbiter
	wb_req_t    eng_req;
	wb_rsp_t    eng_rsp;
	wb_req_t    hp_req;
	wb_rsp_t    hp_rsp;
	// arbiter to ram
	wb_req_t    mem_req;
	wb_rsp_t    mem_rsp;

	spi_pin_sampler u_spi_pin_sampler (
		.clk         (clk),
		.arst_n      (arst_n),
		.sck         (sck),
		.cs_n        (cs_n),
		.mosi        (mosi),
		.miso        (miso),
		.rx_data     (rx_data),
		.rx_valid    (rx_valid),
		.frame_start (frame_start),
		.tx_data     (tx_data)
	);

	flash_read_engine u_flash_read_engine (
		.clk         (clk),
		.arst_n      (arst_n),
		.rx_data     (rx_data),
		.rx_valid    (rx_valid),
		.frame_start (frame_start),
		.tx_data     (tx_data),
		.wb_req      (eng_req),
		.wb_rsp      (eng_rsp)
	);

	host_port u_host_port (
		.clk         (clk),
		.arst_n      (arst_n),
		.host_valid  (host_valid),
		.host_ready  (host_ready),
		.host_req    (host_req),
		.host_rdata  (host_rdata),
		.host_rvalid (host_rvalid),
		.wb_req      (hp_req),
		.wb_rsp      (hp_rsp)
	);

	mem_arbiter u_mem_arbiter (
		.clk      (clk),
		.arst_n   (arst_n),
		.spi_req  (eng_req),
		.spi_rsp  (eng_rsp),
		.host_req (hp_req),
		.host_rsp (hp_rsp),
		.mem_req  (mem_req),
		.mem_rsp  (mem_rsp)
	);

	image_ram u_image_ram (
		.clk    (clk),
		.arst_n (arst_n),
		.wb_req (mem_req),
		.wb_rsp (mem_rsp)
	);

endmodule

`default_nettype wire

/* source/flash_read_engine.sv */
// serves READ and FAST_READ from the image; no writes, erases or status commands
`timescale 1ns/1ps
`default_nettype none

module flash_read_engine import flash_emu_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic [7:0] rx_data,
	input  logic       rx_valid,
	input  logic       frame_start,
	output logic [7:0] tx_data,
	output wb_req_t    wb_req,
	input  wb_rsp_t    wb_rsp
);

	typedef enum logic [2:0] {
		ST_OPCODE,
		ST_ADDR,
		ST_DUMMY,
		ST_STREAM,
		ST_IGNORE
	} state_t;

	state_t                   state;
	logic [1:0]               byte_cnt;
	logic                     fast_q;
	logic                     last_addr;
	// next image address to fetch
	// wraps at the image size
	logic [MEM_ADDR_BITS-1:0] addr_q;
	logic [MEM_ADDR_BITS-1:0] addr_shift;
	logic [MEM_ADDR_BITS-1:0] bus_adr;
	logic [MEM_ADDR_BITS-1:0] fetch_adr;
	logic                     cyc_q;
	logic                     fetch_req;
	logic                     fetch_to_tx;
	logic                     fetch_pend;
	logic                     pend_to_tx;
	// where the data of the bus cycle in flight goes
	logic                     cur_to_tx;
	logic                     cur_stale;
	logic [7:0]               pf_q;
	logic                     ack_used;

	assign last_addr  = (byte_cnt == 2'(SPI_ADDR_BYTES - 1));
	// top address bits fall off and only the image range is kept
	assign addr_shift = {addr_q[MEM_ADDR_BITS-9:0], rx_data};
	assign ack_used   = cyc_q && wb_rsp.ack && !cur_stale && !frame_start;

	assign wb_req.cyc = cyc_q;
	assign wb_req.stb = cyc_q;
	assign wb_req.we  = 1'b0;
	assign wb_req.adr = bus_adr;
	assign wb_req.dat = 8'h00;

	// fetch requests
	always_comb begin
		fetch_req   = 1'b0;
		fetch_to_tx = 1'b0;
		fetch_adr   = addr_q;
		if (rx_valid) begin
			case (state)
				ST_ADDR: begin
					// plain READ starts right after the last address byte
					if (last_addr && !fast_q) begin
						fetch_req   = 1'b1;
						fetch_to_tx = 1'b1;
						fetch_adr   = addr_shift;
					end
				end
				ST_DUMMY: begin
					fetch_req   = 1'b1;
					fetch_to_tx = 1'b1;
				end
				// prefetch the byte after the one now handed over
				ST_STREAM: fetch_req = 1'b1;
				default: fetch_req = 1'b0;
			endcase
		end
		// once the first byte lands the prefetch buffer is filled
		if (ack_used && cur_to_tx) begin
			fetch_req = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= ST_OPCODE;
			byte_cnt   <= 2'd0;
			fast_q     <= 1'b0;
			addr_q     <= '0;
			bus_adr    <= '0;
			tx_data    <= 8'hFF;
			cyc_q      <= 1'b0;
			fetch_pend <= 1'b0;
			pend_to_tx <= 1'b0;
			cur_to_tx  <= 1'b0;
			cur_stale  <= 1'b0;
		end else begin
			if (frame_start) begin
				// a new frame drops the data of any old fetch still in flight
				state      <= ST_OPCODE;
				byte_cnt   <= 2'd0;
				tx_data    <= 8'hFF;
				fetch_pend <= 1'b0;
				cur_stale  <= 1'b1;
			end else if (rx_valid) begin
				case (state)
					ST_OPCODE: begin
						case (spi_op_t'(rx_data))
							OP_READ: begin
								fast_q <= 1'b0;
								state  <= ST_ADDR;
							end
							OP_FAST_READ: begin
								fast_q <= 1'b1;
								state  <= ST_ADDR;
							end
							default: state <= ST_IGNORE;
						endcase
					end
					ST_ADDR: begin
						addr_q   <= addr_shift;
						byte_cnt <= byte_cnt + 2'd1;
						if (last_addr) begin
							state <= fast_q ? ST_DUMMY : ST_STREAM;
						end
					end
					ST_DUMMY:  state <= ST_STREAM;
					ST_STREAM: tx_data <= pf_q;
					default:   state <= ST_IGNORE;
				endcase
			end

			// single wishbone cycles with cyc dropped the cycle after ack
			if (cyc_q && wb_rsp.ack) begin
				cyc_q <= 1'b0;
				if (ack_used && cur_to_tx) begin
					tx_data <= wb_rsp.dat;
				end
				if (fetch_req) begin
					fetch_pend <= 1'b1;
					pend_to_tx <= fetch_to_tx;
				end
			end else if (!cyc_q && !frame_start && (fetch_req || fetch_pend)) begin
				cyc_q      <= 1'b1;
				bus_adr    <= fetch_adr;
				addr_q     <= fetch_adr + MEM_ADDR_BITS'(1);
				cur_to_tx  <= fetch_req ? fetch_to_tx : pend_to_tx;
				cur_stale  <= 1'b0;
				fetch_pend <= 1'b0;
			end else if (fetch_req) begin
				fetch_pend <= 1'b1;
				pend_to_tx <= fetch_to_tx;
			end
		end
	end

	// prefetch buffer
	always_ff @(posedge clk) begin
		if (ack_used && !cur_to_tx) begin
			pf_q <= wb_rsp.dat;
		end
	end

endmodule

`default_nettype wire

/* source/host_port.sv */
// one host byte at a time; a new request waits until the previous bus cycle has ended
`timescale 1ns/1ps
`default_nettype none

module host_port import flash_emu_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       host_valid,
	output logic       host_ready,
	input  host_req_t  host_req,
	output logic [7:0] host_rdata,
	output logic       host_rvalid,
	output wb_req_t    wb_req,
	input  wb_rsp_t    wb_rsp
);

	// bus cycle outstanding
	logic      cyc_q;
	logic      accept;
	host_req_t req_q;

	assign host_ready = !cyc_q;
	assign accept     = host_valid && !cyc_q;

	assign wb_req.cyc = cyc_q;
	assign wb_req.stb = cyc_q;
	assign wb_req.we  = req_q.we;
	assign wb_req.adr = req_q.addr;
	assign wb_req.dat = req_q.data;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cyc_q       <= 1'b0;
			host_rvalid <= 1'b0;
		end else begin
			host_rvalid <= 1'b0;
			if (cyc_q && wb_rsp.ack) begin
				cyc_q <= 1'b0;
				// only reads report back
				host_rvalid <= !req_q.we;
			end else if (accept) begin
				cyc_q <= 1'b1;
			end
		end
	end

	// request and read data registers
	always_ff @(posedge clk) begin
		if (accept) begin
			req_q <= host_req;
		end
		if (cyc_q && wb_rsp.ack && !req_q.we) begin
			host_rdata <= wb_rsp.dat;
		end
	end

endmodule

`default_nettype wire

/* source/image_ram.sv */
// on-chip image ram, one wait state; contents undefined until the host loads them
`timescale 1ns/1ps
`default_nettype none

module image_ram import flash_emu_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  wb_req_t wb_req,
	output wb_rsp_t wb_rsp
);

	logic [7:0] mem [2**MEM_ADDR_BITS];
	logic       ack_q;
	logic [7:0] rdata_q;
	logic       access;

	// first cycle of a strobe, the ack cycle itself is not a new access
	assign access = wb_req.cyc && wb_req.stb && !ack_q;

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = rdata_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ack_q <= 1'b0;
		end else begin
			// one cycle ack
			ack_q <= access;
		end
	end

	// array and registered read
	always_ff @(posedge clk) begin
		if (access) begin
			if (wb_req.we) begin
				mem[wb_req.adr] <= wb_req.dat;
			end
			rdata_q <= mem[wb_req.adr];
		end
	end

endmodule

`default_nettype wire

/* source/mem_arbiter.sv */
// two master wishbone arbiter, spi side wins ties; grant held until ack, no pipelining
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import flash_emu_pkg::*; (
	input  logic    clk,
	input  logic    arst_n,
	input  wb_req_t spi_req,
	output wb_rsp_t spi_rsp,
	input  wb_req_t host_req,
	output wb_rsp_t host_rsp,
	output wb_req_t mem_req,
	input  wb_rsp_t mem_rsp
);

	// busy from grant to ack
	logic busy_q;
	// owner of the bus, 1 is the spi side
	logic grant_q;
	logic grant;

	// when idle the grant follows the requests directly
	// so the first cycle costs no extra clock
	assign grant = busy_q ? grant_q : spi_req.cyc;

	assign mem_req = grant ? spi_req : host_req;

	// ack only to the owner, the other one just waits
	assign spi_rsp.ack  = mem_rsp.ack & grant;
	assign spi_rsp.dat  = mem_rsp.dat;
	assign host_rsp.ack = mem_rsp.ack & ~grant;
	assign host_rsp.dat = mem_rsp.dat;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			busy_q  <= 1'b0;
			grant_q <= 1'b0;
		end else if (!busy_q) begin
			// lock in the winner
			if (spi_req.cyc || host_req.cyc) begin
				busy_q  <= 1'b1;
				grant_q <= spi_req.cyc;
			end
		end else if (mem_rsp.ack) begin
			// owner drops cyc next cycle, free to regrant then
			busy_q <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* source/spi_pin_sampler.sv */
// spi mode 0 slave, msb first; pins oversampled, needs sck half period of 16 clk or more
`timescale 1ns/1ps
`default_nettype none

module spi_pin_sampler (
	input  logic       clk,
	input  logic       arst_n,
	input  logic       sck,
	input  logic       cs_n,
	input  logic       mosi,
	output logic       miso,
	output logic [7:0] rx_data,
	output logic       rx_valid,
	output logic       frame_start,
	input  logic [7:0] tx_data
);

	// two flop synchronizers, index 1 is the safe one
	logic [1:0] sck_sync;
	logic [1:0] cs_sync;
	logic [1:0] mosi_sync;
	// previous synchronized levels for edge detect
	logic       sck_q;
	logic       cs_q;
	logic       sck_rise;
	logic       sck_fall;
	logic [2:0] bit_cnt;
	logic [6:0] rx_shift;
	logic [7:0] tx_shift;

	assign sck_rise    = sck_sync[1] & ~sck_q;
	assign sck_fall    = ~sck_sync[1] & sck_q;
	// chip select just went low
	assign frame_start = cs_q & ~cs_sync[1];
	assign miso        = tx_shift[7];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sck_sync  <= 2'b00;
			cs_sync   <= 2'b11;
			mosi_sync <= 2'b00;
			sck_q     <= 1'b0;
			cs_q      <= 1'b1;
		end else begin
			sck_sync  <= {sck_sync[0], sck};
			cs_sync   <= {cs_sync[0], cs_n};
			mosi_sync <= {mosi_sync[0], mosi};
			sck_q     <= sck_sync[1];
			cs_q      <= cs_sync[1];
		end
	end

	// bit counter, byte strobe and miso shifter
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			bit_cnt  <= 3'd0;
			rx_valid <= 1'b0;
			tx_shift <= 8'hFF;
		end else if (cs_sync[1]) begin
			// deselected: restart the byte, idle miso high
			bit_cnt  <= 3'd0;
			rx_valid <= 1'b0;
			tx_shift <= 8'hFF;
		end else begin
			rx_valid <= sck_rise && (bit_cnt == 3'd7);
			if (sck_rise) begin
				bit_cnt <= bit_cnt + 3'd1;
			end
			// mode 0, data changes on the falling edge
			if (sck_fall) begin
				// byte boundary, bit 7 of the new byte goes out now
				if (bit_cnt == 3'd0) begin
					tx_shift <= tx_data;
				end else begin
					tx_shift <= {tx_shift[6:0], 1'b1};
				end
			end
		end
	end

	// receive data path
	always_ff @(posedge clk) begin
		if (sck_rise) begin
			rx_shift <= {rx_shift[5:0], mosi_sync[1]};
			if (bit_cnt == 3'd7) begin
				rx_data <= {rx_shift, mosi_sync[1]};
			end
		end
	end

endmodule

`default_nettype wire
